// File: logic/cim_aes_pkg.sv
// sizes, counts, state and opcode enums, byte and state types for the cim aes controller
package cim_aes_pkg;

    // ----------------------------------------------------------------------
    // sizes and counts
    // ----------------------------------------------------------------------
    localparam int NUM_BYTES    = 16;
    localparam int NUM_PLANES   = 8;
    // eight slice cycles plus one trailing sample cycle
    localparam int WRITE_CYCLES = 9;
    localparam int LAST_GROUP   = 10;
    localparam int SLICE_W      = 16;

    // ----------------------------------------------------------------------
    // data types
    // ----------------------------------------------------------------------
    typedef logic [7:0] aes_byte_t;

    // byte 0 sits at the most significant end
    typedef aes_byte_t [0:NUM_BYTES-1] aes_state_t;

    typedef logic [SLICE_W-1:0] in_slice_t;
    typedef logic [2:0]         demux_code_t;
    typedef logic [5:0]         row_code_t;

    // 0..8 inside the write phase
    typedef logic [3:0] plane_idx_t;
    // 0..10
    typedef logic [3:0] group_idx_t;

    localparam aes_state_t STATE_RESET = {NUM_BYTES{8'h55}};

    // ----------------------------------------------------------------------
    // FSM phases and mix opcodes
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_WRITE,
        PH_LOOKUP,
        PH_MIX,
        PH_OUT
    } phase_t;

    typedef enum logic [1:0] {
        MIX_NONE,
        MIX_FULL,
        MIX_SHIFT_ONLY
    } mix_op_t;

endpackage

// File: logic/round_ctl_if.sv
// round control bundle from the sequencer to the datapath modules
interface round_ctl_if import cim_aes_pkg::*; ();

    phase_t     phase;
    plane_idx_t plane_idx;
    group_idx_t group_idx;
    mix_op_t    mix_op;
    // one-cycle strobe, sampled together with en
    logic       start;

    modport ctl (
        output phase,
        output plane_idx,
        output group_idx,
        output mix_op,
        output start
    );

    modport follow (
        input phase,
        input plane_idx,
        input group_idx,
        input mix_op,
        input start
    );

endinterface

// File: logic/round_mix.sv
// aes shiftrows with optional mixcolumns over the 128-bit state
module round_mix import cim_aes_pkg::*; (
    input  aes_state_t state,
    input  mix_op_t    op,
    output aes_state_t mixed
);

    // multiply by 2 in GF(2^8)
    function automatic aes_byte_t xtime(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    aes_state_t shifted;
    aes_state_t columns;

    // ----------------------------------------------------------------------
    // shiftrows
    // ----------------------------------------------------------------------
    // byte index is 4*column + row, row r rotates left by r
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[4*c + r] = state[4*((c + r) % 4) + r];
            end
        end
    end

    // ----------------------------------------------------------------------
    // mixcolumns
    // ----------------------------------------------------------------------
    // each row gets 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                columns[4*c + r] = xtime(shifted[4*c + r])
                                 ^ xtime(shifted[4*c + (r + 1) % 4])
                                 ^ shifted[4*c + (r + 1) % 4]
                                 ^ shifted[4*c + (r + 2) % 4]
                                 ^ shifted[4*c + (r + 3) % 4];
            end
        end
    end

    always_comb begin
        case (op)
            MIX_FULL: begin
                mixed = columns;
            end
            MIX_SHIFT_ONLY: begin
                mixed = shifted;
            end
            MIX_NONE: begin
                mixed = state;
            end
            default: begin
                mixed = state;
            end
        endcase
    end

endmodule

// File: logic/round_sequencer.sv
// round sequencer with phase FSM, plane and group counters, mix opcode and status outputs
module round_sequencer import cim_aes_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     en,
    input  logic     kd_rdy,
    round_ctl_if.ctl ctl,
    output logic     kvld,
    output logic     bsy,
    output logic     dvld,
    output logic     write_sel
);

    phase_t     phase_q;
    plane_idx_t plane_q;
    group_idx_t group_q;
    mix_op_t    mix_op;
    logic       start;
    logic       last_plane;
    logic       last_group;
    logic       dvld_q;

    // kd_rdy only counts while idle
    assign start      = en && kd_rdy && (phase_q == PH_IDLE);
    assign last_plane = (plane_q == plane_idx_t'(WRITE_CYCLES - 1));
    assign last_group = (group_q == group_idx_t'(LAST_GROUP));

    // ----------------------------------------------------------------------
    // phase FSM and counters
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase_q <= PH_IDLE;
            plane_q <= '0;
            group_q <= '0;
        end else if (en) begin
            case (phase_q)
                PH_IDLE: begin
                    if (start) begin
                        phase_q <= PH_WRITE;
                        plane_q <= '0;
                        group_q <= '0;
                    end
                end
                PH_WRITE: begin
                    if (last_plane) begin
                        phase_q <= PH_LOOKUP;
                        plane_q <= '0;
                    end else begin
                        plane_q <= plane_q + 1'b1;
                    end
                end
                PH_LOOKUP: begin
                    phase_q <= last_group ? PH_OUT : PH_MIX;
                end
                PH_MIX: begin
                    group_q <= group_q + 1'b1;
                    phase_q <= PH_WRITE;
                end
                PH_OUT: begin
                    phase_q <= PH_IDLE;
                end
                default: begin
                    phase_q <= PH_IDLE;
                end
            endcase
        end
    end

    // group 0 is the plain key add and group 10 skips mixcolumns
    always_comb begin
        if (group_q == '0) begin
            mix_op = MIX_NONE;
        end else if (last_group) begin
            mix_op = MIX_SHIFT_ONLY;
        end else begin
            mix_op = MIX_FULL;
        end
    end

    // ----------------------------------------------------------------------
    // status outputs
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            kvld   <= 1'b0;
            bsy    <= 1'b0;
            dvld_q <= 1'b0;
        end else if (en) begin
            kvld   <= kd_rdy;
            dvld_q <= (phase_q == PH_LOOKUP) && last_group;
            if (start) begin
                bsy <= 1'b1;
            end else if (phase_q == PH_OUT) begin
                bsy <= 1'b0;
            end
        end
    end

    // pulse is held through a stall and shown once en returns
    assign dvld      = dvld_q && en;
    assign write_sel = (phase_q == PH_WRITE);

    assign ctl.phase     = phase_q;
    assign ctl.plane_idx = plane_q;
    assign ctl.group_idx = group_q;
    assign ctl.mix_op    = mix_op;
    assign ctl.start     = start;

    a_plane_cleared: assert property (@(posedge CLK) disable iff (rst)
        (phase_q != PH_WRITE) |-> (plane_q == '0));

    a_dvld_after_last: assert property (@(posedge CLK) disable iff (rst)
        dvld_q |-> ((phase_q == PH_OUT) && last_group));

endmodule

// File: logic/state_writer.sv
// state register, round mixing and 16-bit slice serializer toward the macro
module state_writer import cim_aes_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        en,
    round_ctl_if.follow ctl,
    input  aes_state_t  din,
    input  aes_byte_t   rio [NUM_BYTES],
    output in_slice_t   wr_data
);

    aes_state_t                 state_q;
    aes_state_t                 mixed;
    logic [8*NUM_BYTES-1:0]     mixed_flat;
    logic                       slice_cycle;
    int                         slice_top;

    // din at start, substituted bytes from the macro at each mix step
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state_q <= STATE_RESET;
        end else if (en) begin
            if (ctl.start) begin
                state_q <= din;
            end else if (ctl.phase == PH_MIX) begin
                for (int i = 0; i < NUM_BYTES; i++) begin
                    state_q[i] <= rio[i];
                end
            end
        end
    end

    round_mix u_round_mix (
        .state (state_q),
        .op    (ctl.mix_op),
        .mixed (mixed)
    );

    // ----------------------------------------------------------------------
    // slice serializer with the msb slice first
    // ----------------------------------------------------------------------
    assign mixed_flat  = mixed;
    assign slice_cycle = (ctl.phase == PH_WRITE)
                      && (ctl.plane_idx < plane_idx_t'(NUM_PLANES));
    assign slice_top   = 8 * NUM_BYTES - 1 - SLICE_W * int'(ctl.plane_idx[2:0]);

    // trailing sample cycle drives zero
    assign wr_data = slice_cycle ? mixed_flat[slice_top -: SLICE_W] : '0;

    // one state feeds all eight slices of a group
    a_state_held_in_write: assert property (@(posedge CLK) disable iff (rst)
        (ctl.phase == PH_WRITE) |=> $stable(state_q));

endmodule

// File: logic/plane_gather.sv
// bit-plane to byte transposition buffer and final dout register
module plane_gather import cim_aes_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        en,
    round_ctl_if.follow ctl,
    input  aes_byte_t   rio   [NUM_BYTES],
    output aes_byte_t   bytes [NUM_BYTES],
    output aes_state_t  dout
);

    aes_state_t gather_q;
    logic [2:0] plane;
    logic [2:0] bit_sel;
    logic       capture;

    // plane k is on rio one cycle after its slice went out
    assign capture = (ctl.phase == PH_WRITE) && (ctl.plane_idx != '0);
    assign plane   = 3'(ctl.plane_idx - 1'b1);
    assign bit_sel = 3'd7 - plane;

    // ----------------------------------------------------------------------
    // transposition
    // ----------------------------------------------------------------------
    // lanes 0..7 fill byte 2k and lanes 8..15 fill byte 2k+1
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            gather_q <= '0;
        end else if (en) begin
            if (capture) begin
                for (int j = 0; j < NUM_BYTES / 2; j++) begin
                    gather_q[2*plane][j]     <= rio[j][bit_sel];
                    gather_q[2*plane + 1][j] <= rio[NUM_BYTES / 2 + j][bit_sel];
                end
            end else if (ctl.phase != PH_WRITE) begin
                gather_q <= '0;
            end
        end
    end

    // result of the last key add leaves on the final lookup
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (en && (ctl.phase == PH_LOOKUP)
                     && (ctl.group_idx == group_idx_t'(LAST_GROUP))) begin
            dout <= gather_q;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            bytes[i] = gather_q[i];
        end
    end

    // no stale plane is left when a group starts writing
    a_no_plane_at_zero: assert property (@(posedge CLK) disable iff (rst)
        ((ctl.phase == PH_WRITE) && (ctl.plane_idx == '0)) |-> (gather_q == '0));

endmodule

// File: logic/address_driver.sv
// per-lane column demux and row decoder address generation
module address_driver import cim_aes_pkg::*; (
    round_ctl_if.follow ctl,
    input  aes_byte_t   bytes       [NUM_BYTES],
    output demux_code_t demux_add   [NUM_BYTES],
    output row_code_t   rwl_dec_add [NUM_BYTES]
);

    demux_code_t group_demux;
    row_code_t   group_row;

    // four groups per row, columns 111 down to 100
    assign group_demux = {1'b1, ~ctl.group_idx[1:0]};
    assign group_row   = {4'b0000, ctl.group_idx[3:2]};

    // ----------------------------------------------------------------------
    // lane mux
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            case (ctl.phase)
                PH_WRITE: begin
                    demux_add[i]   = group_demux;
                    rwl_dec_add[i] = group_row;
                end
                PH_LOOKUP: begin
                    // sbox address is the key-added byte itself
                    demux_add[i]   = {1'b0, bytes[i][7:6]};
                    rwl_dec_add[i] = bytes[i][5:0];
                end
                default: begin
                    demux_add[i]   = '0;
                    rwl_dec_add[i] = '0;
                end
            endcase
        end
    end

endmodule

// File: logic/cim_aes_top.sv
// top level of the cim aes round controller with plain ports
module cim_aes_top import cim_aes_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        en,
    input  logic        kd_rdy,
    input  aes_state_t  din,
    input  aes_byte_t   rio         [NUM_BYTES],
    output aes_state_t  dout,
    output logic        kvld,
    output logic        dvld,
    output logic        bsy,
    output in_slice_t   wr_data,
    output logic        write_sel,
    output demux_code_t demux_add   [NUM_BYTES],
    output row_code_t   rwl_dec_add [NUM_BYTES]
);

    // key-added bytes, feeding the lookup addresses
    aes_byte_t gathered [NUM_BYTES];

    round_ctl_if u_ctl ();

    round_sequencer u_sequencer (
        .CLK       (CLK),
        .rst       (rst),
        .en        (en),
        .kd_rdy    (kd_rdy),
        .ctl       (u_ctl.ctl),
        .kvld      (kvld),
        .bsy       (bsy),
        .dvld      (dvld),
        .write_sel (write_sel)
    );

    state_writer u_state_writer (
        .CLK     (CLK),
        .rst     (rst),
        .en      (en),
        .ctl     (u_ctl.follow),
        .din     (din),
        .rio     (rio),
        .wr_data (wr_data)
    );

    plane_gather u_plane_gather (
        .CLK   (CLK),
        .rst   (rst),
        .en    (en),
        .ctl   (u_ctl.follow),
        .rio   (rio),
        .bytes (gathered),
        .dout  (dout)
    );

    address_driver u_address_driver (
        .ctl         (u_ctl.follow),
        .bytes       (gathered),
        .demux_add   (demux_add),
        .rwl_dec_add (rwl_dec_add)
    );

endmodule

// File: tb/tb_clock.sv
// testbench clock source and power-on reset
module tb_clock (
    output logic CLK,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
    end

endmodule

// File: tb/tb_cim_aes.sv
// testbench with macro model, stimulus table, reference encryption, checks and watchdog
module tb_cim_aes import cim_aes_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // din, base key, number of lfsr bits per en decision
    typedef struct packed {
        aes_state_t din;
        aes_state_t key;
        logic [1:0] gap;
    } stim_t;

    localparam int NUM_STIM = 4;
    localparam stim_t STIM [NUM_STIM] = '{
        {128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f, 2'd0},
        {128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c, 2'd1},
        {128'hffffffffffffffffffffffffffffffff, 128'h00000000000000000000000000000000, 2'd3},
        {128'h0123456789abcdeffedcba9876543210, 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0, 2'd2}
    };
    localparam int BLOCK_CYCLES = (LAST_GROUP + 1) * (WRITE_CYCLES + 2) + 4;
    localparam int WATCHDOG_NS  = (NUM_STIM * BLOCK_CYCLES * 4 + 24) * 40;

    logic        CLK;
    logic        rst;
    logic        en = 1'b1;
    logic        kd_rdy = 1'b0;
    aes_state_t  din = '0;
    aes_byte_t   rio [NUM_BYTES] = '{default: 8'h00};
    aes_state_t  dout;
    logic        kvld;
    logic        dvld;
    logic        bsy;
    in_slice_t   wr_data;
    logic        write_sel;
    demux_code_t demux_add   [NUM_BYTES];
    row_code_t   rwl_dec_add [NUM_BYTES];

    aes_state_t  keys        [LAST_GROUP + 1];
    aes_state_t  ref_written [LAST_GROUP + 1];
    aes_state_t  ref_added   [LAST_GROUP + 1];
    logic [15:0] lfsr = 16'd52174;
    int          gap_bits = 0;
    logic [3:0]  wcnt = '0;
    group_idx_t  mgroup = '0;
    logic        was_writing = 1'b0;

    tb_clock u_clock (.CLK(CLK), .rst(rst));

    cim_aes_top DUT (
        .CLK(CLK), .rst(rst), .en(en), .kd_rdy(kd_rdy), .din(din), .rio(rio),
        .dout(dout), .kvld(kvld), .dvld(dvld), .bsy(bsy), .wr_data(wr_data),
        .write_sel(write_sel), .demux_add(demux_add), .rwl_dec_add(rwl_dec_add)
    );

    // ----------------------------------------------------------------------
    // failure reporting and typed compares
    // ----------------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_state(input aes_state_t got, input aes_state_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_slice(input in_slice_t got, input in_slice_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s group %0d slice %0d got %h expected %h",
                                                   what, mgroup, wcnt, got, exp));
    endtask

    task automatic check_demux(input demux_code_t got, input demux_code_t exp, input int lane,
                               input string what);
        if (got !== exp) report_mismatch($sformatf("%s demux lane %0d got %b expected %b",
                                                   what, lane, got, exp));
    endtask

    task automatic check_row(input row_code_t got, input row_code_t exp, input int lane,
                             input string what);
        if (got !== exp) report_mismatch($sformatf("%s row lane %0d got %b expected %b",
                                                   what, lane, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_quiet_outputs(input string what);
        check_flag(dvld, 1'b0, {what, " dvld"});
        check_flag(bsy, 1'b0, {what, " bsy"});
        check_flag(write_sel, 1'b0, {what, " write_sel"});
        check_slice(wr_data, '0, {what, " wr_data"});
        for (int i = 0; i < NUM_BYTES; i++) begin
            check_demux(demux_add[i], '0, i, what);
            check_row(rwl_dec_add[i], '0, i, what);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic aes_byte_t gmul(input aes_byte_t a, input logic [7:0] b);
        aes_byte_t p;
        aes_byte_t x;
        logic [7:0] y;
        p = '0;
        x = a;
        y = b;
        for (int n = 0; n < 8; n++) begin
            if (y[0]) p = p ^ x;
            x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
            y = y >> 1;
        end
        return p;
    endfunction

    // stand-in s-box that the macro model returns
    function automatic aes_byte_t sub_sbox(input aes_byte_t a);
        return {a[6:0], a[7]} ^ 8'h63;
    endfunction

    // state as a 4x4 matrix with byte 4*col + row
    function automatic aes_state_t ref_mix(input aes_state_t s, input int g);
        aes_byte_t  m [4][4];
        aes_state_t r;
        for (int row = 0; row < 4; row++)
            for (int col = 0; col < 4; col++)
                m[row][col] = s[4 * ((col + row) % 4) + row];
        for (int col = 0; col < 4; col++) begin
            for (int row = 0; row < 4; row++) begin
                if (g == LAST_GROUP)
                    r[4 * col + row] = m[row][col];
                else
                    r[4 * col + row] = gmul(m[row][col], 8'd2) ^ gmul(m[(row + 1) % 4][col], 8'd3)
                                     ^ m[(row + 2) % 4][col] ^ m[(row + 3) % 4][col];
            end
        end
        if (g == 0) return s;
        return r;
    endfunction

    task automatic build_reference(input aes_state_t din_v, input aes_state_t key_base);
        aes_state_t cur;
        cur = din_v;
        for (int g = 0; g <= LAST_GROUP; g++) begin
            for (int i = 0; i < NUM_BYTES; i++) keys[g][i] = key_base[i] ^ 8'(g * 29 + i * 3);
            ref_written[g] = ref_mix(cur, g);
            for (int i = 0; i < NUM_BYTES; i++) begin
                ref_added[g][i] = ref_written[g][i] ^ keys[g][i];
                cur[i] = sub_sbox(ref_added[g][i]);
            end
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // en low only when all taken bits are ones
    always @(posedge CLK) begin : en_gaps
        logic all_ones;
        all_ones = (gap_bits != 0);
        for (int n = 0; n < gap_bits; n++) begin
            all_ones = all_ones & lfsr[15];
            lfsr = lfsr_next(lfsr);
        end
        en <= !all_ones;
    end

    // ----------------------------------------------------------------------
    // macro model returning planes one cycle after each slice and s-box bytes after lookup
    // ----------------------------------------------------------------------
    always @(posedge CLK) begin : macro_model
        in_slice_t   v;
        logic [2:0]  b;
        aes_byte_t   x;
        if (!rst && en) begin
            if (write_sel) begin
                for (int i = 0; i < NUM_BYTES; i++) begin
                    check_demux(demux_add[i], 3'd7 - {1'b0, mgroup[1:0]}, i, "write group");
                    check_row(rwl_dec_add[i], row_code_t'(mgroup / 4), i, "write group");
                end
                if (wcnt < 4'(NUM_PLANES)) begin
                    check_slice(wr_data, {ref_written[mgroup][{wcnt[2:0], 1'b0}],
                                          ref_written[mgroup][{wcnt[2:0], 1'b1}]}, "wr_data");
                    v = wr_data ^ {keys[mgroup][{wcnt[2:0], 1'b0}],
                                   keys[mgroup][{wcnt[2:0], 1'b1}]};
                    b = 3'd7 - wcnt[2:0];
                    for (int j = 0; j < 8; j++) begin
                        rio[j][b]     <= v[8 + j];
                        rio[8 + j][b] <= v[j];
                    end
                end else begin
                    check_slice(wr_data, '0, "wr_data on sample cycle");
                end
                wcnt = wcnt + 4'd1;
            end else if (was_writing) begin
                for (int i = 0; i < NUM_BYTES; i++) begin
                    x = ref_added[mgroup][i];
                    check_demux(demux_add[i], {1'b0, x[7:6]}, i, "lookup");
                    check_row(rwl_dec_add[i], x[5:0], i, "lookup");
                    rio[i] <= sub_sbox({demux_add[i][1:0], rwl_dec_add[i]});
                end
                wcnt = '0;
                mgroup = (mgroup == group_idx_t'(LAST_GROUP)) ? '0 : mgroup + 4'd1;
            end else begin
                for (int i = 0; i < NUM_BYTES; i++) begin
                    check_demux(demux_add[i], '0, i, "mix or idle");
                    check_row(rwl_dec_add[i], '0, i, "mix or idle");
                end
            end
            was_writing = write_sel;
        end
    end

    always @(negedge CLK) begin
        if (!rst && dvld && !en) report_mismatch("dvld high while en is low");
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog expired before all blocks completed");
    end

    // ----------------------------------------------------------------------
    // stimulus table loop
    // ----------------------------------------------------------------------
    initial begin
        @(negedge rst);
        @(negedge CLK);
        check_quiet_outputs("after reset");
        check_flag(kvld, 1'b0, "after reset kvld");
        check_state(dout, '0, "after reset dout");
        for (int t = 0; t < NUM_STIM; t++) begin
            @(negedge CLK);
            check_quiet_outputs("idle");
            check_flag(kvld, 1'b0, "idle kvld");
            gap_bits = int'(STIM[t].gap);
            build_reference(STIM[t].din, STIM[t].key);
            @(posedge CLK);
            din    <= STIM[t].din;
            kd_rdy <= 1'b1;
            @(posedge CLK);
            while (!en) @(posedge CLK);
            kd_rdy <= 1'b0;
            @(negedge CLK);
            check_flag(kvld, 1'b1, "kvld after kd_rdy");
            check_flag(bsy, 1'b1, "bsy after start");
            check_flag(write_sel, 1'b1, "write_sel after start");
            do begin
                @(negedge CLK);
                check_flag(bsy, 1'b1, "bsy while running");
            end while (!dvld);
            check_state(dout, ref_added[LAST_GROUP], "dout at dvld");
            @(negedge CLK);
            check_flag(bsy, 1'b0, "bsy after output");
            check_flag(dvld, 1'b0, "dvld after output");
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: cim_aes.f
logic/cim_aes_pkg.sv
logic/round_ctl_if.sv
logic/round_mix.sv
logic/round_sequencer.sv
logic/state_writer.sv
logic/plane_gather.sv
logic/address_driver.sv
logic/cim_aes_top.sv
tb/tb_clock.sv
tb/tb_cim_aes.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv --top-module tb_cim_aes \
    -Mdir obj_dir -o sim_cim_aes -f cim_aes.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cim_aes > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
